// ==== hdl/hub_cfg.svh ====
// Transaction hub configuration
`ifndef HUB_CFG_SVH
`define HUB_CFG_SVH

////////////////////////////////////////
// Port side
////////////////////////////////////////

`define HUB_NUM_PORTS  4
`define HUB_PORT_IDX_W 2  // Enough bits to name every port
`define HUB_ID_W       3

`define HUB_ADDR_W     16
`define HUB_DATA_W     32

////////////////////////////////////////
// Master side
////////////////////////////////////////

// One transaction per slot, so this bounds outstanding requests
`define HUB_SLOTS      4
`define HUB_SLOT_W     2
`define HUB_FIFO_DEPTH 4

`endif

// ==== hdl/hub_pkg.sv ====
// Transaction hub types
`include "hub_cfg.svh"

package hub_pkg;

  typedef logic [`HUB_PORT_IDX_W-1:0]          port_idx_t;
  typedef logic [`HUB_ID_W-1:0]                txn_id_t;
  typedef logic [`HUB_PORT_IDX_W+`HUB_ID_W-1:0] wide_id_t;  // Port index on top
  typedef logic [`HUB_SLOT_W-1:0]              slot_id_t;
  typedef logic [`HUB_ADDR_W-1:0]              addr_t;
  typedef logic [`HUB_DATA_W-1:0]              data_t;

  // Request as issued by a port
  typedef struct packed {
    logic    wr;
    txn_id_t id;
    addr_t   addr;
    data_t   data;
  } req_t;

  typedef struct packed {
    logic     wr;
    wide_id_t id;
    addr_t    addr;
    data_t    data;
  } tagged_req_t;

  typedef struct packed {
    logic     wr;
    slot_id_t id;  // Remap slot
    addr_t    addr;
    data_t    data;
  } mst_req_t;

  typedef struct packed {slot_id_t id; data_t data; logic err;} mst_rsp_t;
  typedef struct packed {txn_id_t id; data_t data; logic err;} port_rsp_t;
  typedef struct packed {wide_id_t id; data_t data; logic err;} wide_rsp_t;

  // Four-phase handshake progress
  typedef enum logic [1:0] {
    IDLE,
    WAIT_ACK,
    WAIT_RELEASE
  } hs_state_e;

endpackage

// ==== hdl/port_arbiter.sv ====
// Round-robin port arbiter
`timescale 1ns/10ps
`include "hub_cfg.svh"

module port_arbiter (
  input  logic                                    periph_clk,
  input  logic                                    rst_n_i,
  input  logic [`HUB_NUM_PORTS-1:0]               port_req_i,
  input  hub_pkg::req_t [`HUB_NUM_PORTS-1:0]      port_req_data_i,
  output logic [`HUB_NUM_PORTS-1:0]               port_ack_o,
  output logic                                    push_o,
  output hub_pkg::tagged_req_t                    push_data_o,
  input  logic                                    full_i,
  input  logic                                    wide_rsp_valid_i,
  input  hub_pkg::wide_rsp_t                      wide_rsp_i,
  output logic                                    wide_rsp_ready_o,
  output logic [`HUB_NUM_PORTS-1:0]               port_rsp_req_o,
  output hub_pkg::port_rsp_t [`HUB_NUM_PORTS-1:0] port_rsp_o,
  input  logic [`HUB_NUM_PORTS-1:0]               port_rsp_ack_i
);

  hub_pkg::port_idx_t        rr_q;
  hub_pkg::port_idx_t        cand;
  hub_pkg::port_idx_t        grant_idx;
  logic                      grant_vld;
  logic                      grant;
  logic [`HUB_NUM_PORTS-1:0] elig;

  hub_pkg::hs_state_e ack_st_q [`HUB_NUM_PORTS];
  hub_pkg::hs_state_e rsp_st_q [`HUB_NUM_PORTS];
  hub_pkg::port_rsp_t rsp_q    [`HUB_NUM_PORTS];

  hub_pkg::port_idx_t rsp_port;
  hub_pkg::txn_id_t   rsp_id;
  logic               rsp_take;

  ////////////////////////////////////////
  // Request grant
  ////////////////////////////////////////

  // Scan from the pointer, first eligible port wins
  always_comb begin
    grant_vld = 1'b0;
    grant_idx = rr_q;
    cand      = rr_q;
    for (int i = `HUB_NUM_PORTS - 1; i >= 0; i--) begin
      cand = hub_pkg::port_idx_t'((int'(rr_q) + i) % `HUB_NUM_PORTS);
      if (elig[cand]) begin
        grant_vld = 1'b1;
        grant_idx = cand;
      end
    end
  end

  assign grant  = grant_vld && !full_i;  // Full FIFO stalls everything
  assign push_o = grant;

  always_comb begin
    push_data_o.wr   = port_req_data_i[grant_idx].wr;
    push_data_o.id   = {grant_idx, port_req_data_i[grant_idx].id};
    push_data_o.addr = port_req_data_i[grant_idx].addr;
    push_data_o.data = port_req_data_i[grant_idx].data;
  end

  always_ff @(posedge periph_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q <= '0;
    end else if (grant) begin
      rr_q <= hub_pkg::port_idx_t'((int'(grant_idx) + 1) % `HUB_NUM_PORTS);
    end
  end

  ////////////////////////////////////////
  // Response return
  ////////////////////////////////////////

  assign rsp_port = wide_rsp_i.id[`HUB_PORT_IDX_W+`HUB_ID_W-1 -: `HUB_PORT_IDX_W];
  assign rsp_id   = wide_rsp_i.id[`HUB_ID_W-1:0];

  // Only an idle port may take a new response
  assign wide_rsp_ready_o = (rsp_st_q[rsp_port] == hub_pkg::IDLE);
  assign rsp_take         = wide_rsp_valid_i && wide_rsp_ready_o;

  for (genvar p = 0; p < `HUB_NUM_PORTS; p++) begin : gen_port
    assign elig[p]           = port_req_i[p] && (ack_st_q[p] == hub_pkg::IDLE);
    assign port_ack_o[p]     = (ack_st_q[p] == hub_pkg::WAIT_RELEASE);
    assign port_rsp_req_o[p] = (rsp_st_q[p] == hub_pkg::WAIT_ACK);
    assign port_rsp_o[p]     = rsp_q[p];

    always_ff @(posedge periph_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
        ack_st_q[p] <= hub_pkg::IDLE;
      end else begin
        case (ack_st_q[p])
          hub_pkg::IDLE: begin
            if (grant && grant_idx == hub_pkg::port_idx_t'(p)) begin
              ack_st_q[p] <= hub_pkg::WAIT_RELEASE;
            end
          end
          hub_pkg::WAIT_RELEASE: begin
            if (!port_req_i[p]) ack_st_q[p] <= hub_pkg::IDLE;  // Source let go
          end
          default: ack_st_q[p] <= hub_pkg::IDLE;
        endcase
      end
    end

    always_ff @(posedge periph_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
        rsp_st_q[p] <= hub_pkg::IDLE;
      end else begin
        case (rsp_st_q[p])
          hub_pkg::IDLE: begin
            if (rsp_take && rsp_port == hub_pkg::port_idx_t'(p)) begin
              rsp_st_q[p] <= hub_pkg::WAIT_ACK;
            end
          end
          hub_pkg::WAIT_ACK: begin
            if (port_rsp_ack_i[p]) rsp_st_q[p] <= hub_pkg::WAIT_RELEASE;
          end
          hub_pkg::WAIT_RELEASE: begin
            if (!port_rsp_ack_i[p]) rsp_st_q[p] <= hub_pkg::IDLE;
          end
          default: rsp_st_q[p] <= hub_pkg::IDLE;
        endcase
      end
    end

    always_ff @(posedge periph_clk) begin
      if (rsp_take && rsp_port == hub_pkg::port_idx_t'(p)) begin
        rsp_q[p] <= {rsp_id, wide_rsp_i.data, wide_rsp_i.err};  // Restore port ID
      end
    end
  end

  // At most one new ack per cycle
  a_single_ack_rise: assert property (@(posedge periph_clk) disable iff (!rst_n_i)
    $onehot0(port_ack_o & ~$past(port_ack_o)));

endmodule

// ==== hdl/req_fifo.sv ====
// Tagged request FIFO
`timescale 1ns/10ps
`include "hub_cfg.svh"

module req_fifo (
  input  logic                 periph_clk,
  input  logic                 rst_n_i,
  input  logic                 push_i,
  input  hub_pkg::tagged_req_t push_data_i,
  output logic                 full_o,
  input  logic                 pop_i,
  output hub_pkg::tagged_req_t pop_data_o,
  output logic                 empty_o
);

  localparam int unsigned PTR_W = $clog2(`HUB_FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(`HUB_FIFO_DEPTH + 1);

  hub_pkg::tagged_req_t mem_q [`HUB_FIFO_DEPTH];
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [CNT_W-1:0]     cnt_q;
  logic                 do_push;
  logic                 do_pop;

  assign full_o     = (cnt_q == CNT_W'(`HUB_FIFO_DEPTH));
  assign empty_o    = (cnt_q == '0);
  assign do_push    = push_i && !full_o;
  assign do_pop     = pop_i && !empty_o;
  assign pop_data_o = mem_q[rd_ptr_q];  // Head always visible

  always_ff @(posedge periph_clk) begin
    if (do_push) mem_q[wr_ptr_q] <= push_data_i;
  end

  always_ff @(posedge periph_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`HUB_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`HUB_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  ////////////////////////////////////////
  // Neighbour protocol checks
  ////////////////////////////////////////

  a_no_push_full: assert property (@(posedge periph_clk) disable iff (!rst_n_i)
    full_o |-> !push_i);

  a_no_pop_empty: assert property (@(posedge periph_clk) disable iff (!rst_n_i)
    empty_o |-> !pop_i);

endmodule

// ==== hdl/id_remap.sv ====
// ID remapper towards the master port
`timescale 1ns/10ps
`include "hub_cfg.svh"

module id_remap (
  input  logic                 periph_clk,
  input  logic                 rst_n_i,
  output logic                 pop_o,
  input  hub_pkg::tagged_req_t pop_data_i,
  input  logic                 empty_i,
  output logic                 mst_req_o,
  output hub_pkg::mst_req_t    mst_req_data_o,
  input  logic                 mst_ack_i,
  input  logic                 mst_rsp_req_i,
  input  hub_pkg::mst_rsp_t    mst_rsp_i,
  output logic                 mst_rsp_ack_o,
  output logic                 wide_rsp_valid_o,
  output hub_pkg::wide_rsp_t   wide_rsp_o,
  input  logic                 wide_rsp_ready_i
);

  // Slot table
  logic [`HUB_SLOTS-1:0] busy_q;
  hub_pkg::wide_id_t     wid_q [`HUB_SLOTS];
  hub_pkg::slot_id_t     alloc_idx;
  logic                  alloc_vld;

  hub_pkg::hs_state_e req_st_q;
  hub_pkg::hs_state_e rsp_st_q;
  hub_pkg::mst_req_t  mst_req_q;
  hub_pkg::wide_rsp_t wide_rsp_q;
  hub_pkg::slot_id_t  rsp_slot_q;
  logic               rsp_capture;
  logic               rsp_done;

  // Lowest free slot
  always_comb begin
    alloc_vld = 1'b0;
    alloc_idx = '0;
    for (int s = `HUB_SLOTS - 1; s >= 0; s--) begin
      if (!busy_q[s]) begin
        alloc_vld = 1'b1;
        alloc_idx = hub_pkg::slot_id_t'(s);
      end
    end
  end

  assign pop_o = !empty_i && alloc_vld && (req_st_q == hub_pkg::IDLE);

  assign rsp_capture = (rsp_st_q == hub_pkg::IDLE) && mst_rsp_req_i;
  assign rsp_done    = (rsp_st_q == hub_pkg::WAIT_ACK) && wide_rsp_ready_i;

  assign mst_req_o        = (req_st_q == hub_pkg::WAIT_ACK);
  assign mst_req_data_o   = mst_req_q;
  assign wide_rsp_valid_o = (rsp_st_q == hub_pkg::WAIT_ACK);
  assign wide_rsp_o       = wide_rsp_q;
  assign mst_rsp_ack_o    = (rsp_st_q == hub_pkg::WAIT_RELEASE);

  ////////////////////////////////////////
  // Slot bookkeeping
  ////////////////////////////////////////

  // Set and clear never hit the same slot
  always_ff @(posedge periph_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= '0;
    end else begin
      if (pop_o) busy_q[alloc_idx] <= 1'b1;
      if (rsp_done) busy_q[rsp_slot_q] <= 1'b0;
    end
  end

  always_ff @(posedge periph_clk) begin
    if (pop_o) begin
      wid_q[alloc_idx] <= pop_data_i.id;
      mst_req_q.wr     <= pop_data_i.wr;
      mst_req_q.id     <= alloc_idx;  // Narrow ID is the slot number
      mst_req_q.addr   <= pop_data_i.addr;
      mst_req_q.data   <= pop_data_i.data;
    end
    if (rsp_capture) begin
      wide_rsp_q.id   <= wid_q[mst_rsp_i.id];
      wide_rsp_q.data <= mst_rsp_i.data;
      wide_rsp_q.err  <= mst_rsp_i.err;
      rsp_slot_q      <= mst_rsp_i.id;
    end
  end

  ////////////////////////////////////////
  // Master handshakes
  ////////////////////////////////////////

  always_ff @(posedge periph_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_st_q <= hub_pkg::IDLE;
    end else begin
      case (req_st_q)
        hub_pkg::IDLE:         if (pop_o) req_st_q <= hub_pkg::WAIT_ACK;
        hub_pkg::WAIT_ACK:     if (mst_ack_i) req_st_q <= hub_pkg::WAIT_RELEASE;
        hub_pkg::WAIT_RELEASE: if (!mst_ack_i) req_st_q <= hub_pkg::IDLE;
        default:               req_st_q <= hub_pkg::IDLE;
      endcase
    end
  end

  // WAIT_ACK here means the response waits on the arbiter
  always_ff @(posedge periph_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_st_q <= hub_pkg::IDLE;
    end else begin
      case (rsp_st_q)
        hub_pkg::IDLE:         if (mst_rsp_req_i) rsp_st_q <= hub_pkg::WAIT_ACK;
        hub_pkg::WAIT_ACK:     if (wide_rsp_ready_i) rsp_st_q <= hub_pkg::WAIT_RELEASE;
        hub_pkg::WAIT_RELEASE: if (!mst_rsp_req_i) rsp_st_q <= hub_pkg::IDLE;
        default:               rsp_st_q <= hub_pkg::IDLE;
      endcase
    end
  end

  a_rsp_slot_busy: assert property (@(posedge periph_clk) disable iff (!rst_n_i)
    rsp_capture |-> busy_q[mst_rsp_i.id]);

  // Allocated slot is free at pop and held busy once the request is out
  a_issue_free_slot: assert property (@(posedge periph_clk) disable iff (!rst_n_i)
    pop_o |-> !busy_q[alloc_idx] ##1 (mst_req_o && busy_q[mst_req_data_o.id]));

endmodule

// ==== hdl/xbar_hub.sv ====
// Transaction hub top level
`timescale 1ns/10ps
`include "hub_cfg.svh"

module xbar_hub (
  input  logic                                    periph_clk,
  input  logic                                    rst_n_i,
  // Request ports
  input  logic [`HUB_NUM_PORTS-1:0]               port_req_i,
  input  hub_pkg::req_t [`HUB_NUM_PORTS-1:0]      port_req_data_i,
  output logic [`HUB_NUM_PORTS-1:0]               port_ack_o,
  output logic [`HUB_NUM_PORTS-1:0]               port_rsp_req_o,
  output hub_pkg::port_rsp_t [`HUB_NUM_PORTS-1:0] port_rsp_o,
  input  logic [`HUB_NUM_PORTS-1:0]               port_rsp_ack_i,
  // Master port
  output logic                                    mst_req_o,
  output hub_pkg::mst_req_t                       mst_req_data_o,
  input  logic                                    mst_ack_i,
  input  logic                                    mst_rsp_req_i,
  input  hub_pkg::mst_rsp_t                       mst_rsp_i,
  output logic                                    mst_rsp_ack_o
);

  logic                 push;
  hub_pkg::tagged_req_t push_data;
  logic                 full;
  logic                 pop;
  hub_pkg::tagged_req_t pop_data;
  logic                 empty;
  logic                 wide_rsp_valid;
  hub_pkg::wide_rsp_t   wide_rsp;
  logic                 wide_rsp_ready;

  port_arbiter i_port_arbiter (
    .periph_clk       ( periph_clk      ),
    .rst_n_i          ( rst_n_i         ),
    .port_req_i       ( port_req_i      ),
    .port_req_data_i  ( port_req_data_i ),
    .port_ack_o       ( port_ack_o      ),
    .push_o           ( push            ),
    .push_data_o      ( push_data       ),
    .full_i           ( full            ),
    .wide_rsp_valid_i ( wide_rsp_valid  ),
    .wide_rsp_i       ( wide_rsp        ),
    .wide_rsp_ready_o ( wide_rsp_ready  ),
    .port_rsp_req_o   ( port_rsp_req_o  ),
    .port_rsp_o       ( port_rsp_o      ),
    .port_rsp_ack_i   ( port_rsp_ack_i  )
  );

  req_fifo i_req_fifo (
    .periph_clk  ( periph_clk ),
    .rst_n_i     ( rst_n_i    ),
    .push_i      ( push       ),
    .push_data_i ( push_data  ),
    .full_o      ( full       ),
    .pop_i       ( pop        ),
    .pop_data_o  ( pop_data   ),
    .empty_o     ( empty      )
  );

  id_remap i_id_remap (
    .periph_clk       ( periph_clk     ),
    .rst_n_i          ( rst_n_i        ),
    .pop_o            ( pop            ),
    .pop_data_i       ( pop_data       ),
    .empty_i          ( empty          ),
    .mst_req_o        ( mst_req_o      ),
    .mst_req_data_o   ( mst_req_data_o ),
    .mst_ack_i        ( mst_ack_i      ),
    .mst_rsp_req_i    ( mst_rsp_req_i  ),
    .mst_rsp_i        ( mst_rsp_i      ),
    .mst_rsp_ack_o    ( mst_rsp_ack_o  ),
    .wide_rsp_valid_o ( wide_rsp_valid ),
    .wide_rsp_o       ( wide_rsp       ),
    .wide_rsp_ready_i ( wide_rsp_ready )
  );

endmodule

// ==== verification/tb_xbar_hub.sv ====
// Transaction hub testbench
`timescale 1ns/10ps
`include "hub_cfg.svh"

module tb_xbar_hub;

  localparam logic [31:0] SEED        = 32'd77386;
  localparam int          MEM_WORDS   = 256;
  localparam int          CYCLE_LIMIT = 4000;
  localparam int          NUM_IDS     = 1 << `HUB_ID_W;
  localparam int          MAX_OUT     = 4;  // Per port, leaves a free ID

  logic                                    periph_clk;
  logic                                    rst_n_i;
  logic [`HUB_NUM_PORTS-1:0]               port_req_i;
  hub_pkg::req_t [`HUB_NUM_PORTS-1:0]      port_req_data_i;
  logic [`HUB_NUM_PORTS-1:0]               port_ack_o;
  logic [`HUB_NUM_PORTS-1:0]               port_rsp_req_o;
  hub_pkg::port_rsp_t [`HUB_NUM_PORTS-1:0] port_rsp_o;
  logic [`HUB_NUM_PORTS-1:0]               port_rsp_ack_i;
  logic                                    mst_req_o;
  hub_pkg::mst_req_t                       mst_req_data_o;
  logic                                    mst_ack_i;
  logic                                    mst_rsp_req_i;
  hub_pkg::mst_rsp_t                       mst_rsp_i;
  logic                                    mst_rsp_ack_o;

  logic [31:0] rng_state = SEED;
  int          errors    = 0;
  int          err_mark  = 0;
  int          test_num  = 0;
  int          pass_cnt  = 0;
  int          fail_cnt  = 0;
  int          cycles    = 0;
  int          n_issued  = 0;
  int          n_done    = 0;
  int          n_rsp     = 0;
  int          n_mst     = 0;
  int          n_out     = 0;
  logic        hold_rsp;
  logic        rsp_slow;

  // Port side scoreboard
  logic [NUM_IDS-1:0] exp_vld   [`HUB_NUM_PORTS];
  hub_pkg::data_t     exp_data  [`HUB_NUM_PORTS][NUM_IDS];
  int                 exp_addr  [`HUB_NUM_PORTS][NUM_IDS];
  int                 out_cnt   [`HUB_NUM_PORTS];
  hub_pkg::data_t     ref_mem   [MEM_WORDS];
  logic               addr_busy [MEM_WORDS];

  // Master side expectations and memory model state
  logic                     exp_mst_vld  [MEM_WORDS];
  logic                     exp_mst_wr   [MEM_WORDS];
  hub_pkg::data_t           exp_mst_data [MEM_WORDS];
  logic                     exp_err      [MEM_WORDS];
  hub_pkg::data_t           mem          [MEM_WORDS];
  logic [`HUB_SLOTS-1:0]    pend_vld;
  hub_pkg::data_t           pend_data    [`HUB_SLOTS];
  logic                     pend_err     [`HUB_SLOTS];

  logic                      req_seen;
  logic [`HUB_NUM_PORTS-1:0] ack_prev;
  logic [1:0]                pass_cnt_q [`HUB_NUM_PORTS][`HUB_NUM_PORTS];
  logic                      unfair;

  xbar_hub uut (
    .periph_clk      ( periph_clk      ),
    .rst_n_i         ( rst_n_i         ),
    .port_req_i      ( port_req_i      ),
    .port_req_data_i ( port_req_data_i ),
    .port_ack_o      ( port_ack_o      ),
    .port_rsp_req_o  ( port_rsp_req_o  ),
    .port_rsp_o      ( port_rsp_o      ),
    .port_rsp_ack_i  ( port_rsp_ack_i  ),
    .mst_req_o       ( mst_req_o       ),
    .mst_req_data_o  ( mst_req_data_o  ),
    .mst_ack_i       ( mst_ack_i       ),
    .mst_rsp_req_i   ( mst_rsp_req_i   ),
    .mst_rsp_i       ( mst_rsp_i       ),
    .mst_rsp_ack_o   ( mst_rsp_ack_o   )
  );

  initial begin
    periph_clk = 1'b0;
    forever #20 periph_clk = ~periph_clk;
  end

  always @(posedge periph_clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  function automatic int unsigned pick(input int unsigned n);
    return xorshift() % n;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    assert (actual === expected) else begin
      errors = errors + 1;
      $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
               $time, name, expected, actual);
    end
  endtask

  ////////////////////////////////////////
  // Port models
  ////////////////////////////////////////

  task automatic issue_req(input int p, input logic wr, input int fixed_addr);
    hub_pkg::req_t r;
    int            a;
    @(negedge periph_clk);
    while (out_cnt[p] >= MAX_OUT) @(negedge periph_clk);
    a = fixed_addr;
    while (a < 0 || addr_busy[a]) a = int'(pick(MEM_WORDS));
    r.wr   = wr;
    r.addr = hub_pkg::addr_t'(a);
    r.data = xorshift();
    r.id   = hub_pkg::txn_id_t'(pick(NUM_IDS));
    while (exp_vld[p][r.id]) r.id = hub_pkg::txn_id_t'(pick(NUM_IDS));
    exp_vld[p][r.id]  = 1'b1;
    exp_data[p][r.id] = wr ? r.data : ref_mem[a];  // Unwritten words read as zero
    exp_addr[p][r.id] = a;
    if (wr) ref_mem[a] = r.data;
    addr_busy[a]    = 1'b1;
    exp_mst_vld[a]  = 1'b1;
    exp_mst_wr[a]   = wr;
    exp_mst_data[a] = r.data;
    out_cnt[p]      = out_cnt[p] + 1;
    n_issued        = n_issued + 1;
    port_req_data_i[p] = r;
    port_req_i[p]      = 1'b1;
    @(negedge periph_clk);
    while (!port_ack_o[p]) @(negedge periph_clk);
    port_req_i[p] = 1'b0;
    @(negedge periph_clk);
    while (port_ack_o[p]) @(negedge periph_clk);
  endtask

  task automatic port_traffic(input int p, input int n, input int max_gap);
    repeat (n) begin
      if (max_gap > 0) repeat (pick(max_gap)) @(negedge periph_clk);
      issue_req(p, pick(2) == 0, -1);
    end
  endtask

  task automatic run_all_ports(input int n, input int max_gap);
    fork
      port_traffic(0, n, max_gap);
      port_traffic(1, n, max_gap);
      port_traffic(2, n, max_gap);
      port_traffic(3, n, max_gap);
    join
  endtask

  for (genvar p = 0; p < `HUB_NUM_PORTS; p++) begin : gen_port_model
    initial begin : rsp_side
      hub_pkg::port_rsp_t rsp;
      forever begin
        @(negedge periph_clk);
        if (port_rsp_req_o[p] && !port_rsp_ack_i[p]) begin
          rsp = port_rsp_o[p];
          if (rsp_slow) repeat (pick(6)) @(negedge periph_clk);
          port_rsp_ack_i[p] = 1'b1;
          @(negedge periph_clk);
          while (port_rsp_req_o[p]) @(negedge periph_clk);
          n_rsp = n_rsp + 1;
          if (exp_vld[p][rsp.id]) begin
            addr_busy[exp_addr[p][rsp.id]] = 1'b0;
            exp_vld[p][rsp.id] = 1'b0;
            out_cnt[p] = out_cnt[p] - 1;
            n_done = n_done + 1;
          end
          port_rsp_ack_i[p] = 1'b0;
        end
      end
    end

    a_rsp_known: assert property (@(posedge periph_clk) disable iff (!rst_n_i)
      $rose(port_rsp_req_o[p]) |-> exp_vld[p][port_rsp_o[p].id])
      else begin
        errors = errors + 1;
        $display("Port %0d got a response for ID %0d it has not outstanding, at %0t",
                 p, $sampled(port_rsp_o[p].id), $time);
      end

    a_rsp_data: assert property (@(posedge periph_clk) disable iff (!rst_n_i)
      $rose(port_rsp_req_o[p]) && exp_vld[p][port_rsp_o[p].id]
        |-> port_rsp_o[p].data == exp_data[p][port_rsp_o[p].id])
      else begin
        errors = errors + 1;
        $display("MISMATCH time=%0t signal=port_rsp_o[%0d].data expected=%h actual=%h",
                 $time, p, $sampled(exp_data[p][port_rsp_o[p].id]),
                 $sampled(port_rsp_o[p].data));
      end

    a_rsp_err: assert property (@(posedge periph_clk) disable iff (!rst_n_i)
      $rose(port_rsp_req_o[p]) && exp_vld[p][port_rsp_o[p].id]
        |-> port_rsp_o[p].err == exp_err[exp_addr[p][port_rsp_o[p].id]])
      else begin
        errors = errors + 1;
        $display("MISMATCH time=%0t signal=port_rsp_o[%0d].err expected=%b actual=%b",
                 $time, p, $sampled(exp_err[exp_addr[p][port_rsp_o[p].id]]),
                 $sampled(port_rsp_o[p].err));
      end

    // Response handshake runs its four phases in order
    a_rsp_hold: assert property (@(posedge periph_clk) disable iff (!rst_n_i)
      port_rsp_req_o[p] && !port_rsp_ack_i[p] |=> port_rsp_req_o[p])
      else begin
        errors = errors + 1;
        $display("Port %0d response req dropped before its ack, at %0t", p, $time);
      end

    a_rsp_release: assert property (@(posedge periph_clk) disable iff (!rst_n_i)
      port_rsp_req_o[p] && port_rsp_ack_i[p] |=> !port_rsp_req_o[p])
      else begin
        errors = errors + 1;
        $display("Port %0d response req stayed high after its ack, at %0t", p, $time);
      end

    a_ack_hold: assert property (@(posedge periph_clk) disable iff (!rst_n_i)
      port_ack_o[p] && port_req_i[p] |=> port_ack_o[p])
      else begin
        errors = errors + 1;
        $display("Port %0d ack fell while its req was still high, at %0t", p, $time);
      end
  end

  ////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////

  task automatic check_master_req(input hub_pkg::mst_req_t m);
    a_mst_known: assert (exp_mst_vld[m.addr] === 1'b1) else begin
      errors = errors + 1;
      $display("Master request to address %h at %0t is unknown or repeated", m.addr, $time);
    end
    if (exp_mst_vld[m.addr] === 1'b1) begin
      compare_value("mst_req_data_o.wr", 32'(exp_mst_wr[m.addr]), 32'(m.wr));
      compare_value("mst_req_data_o.data", exp_mst_data[m.addr], m.data);
    end
    a_slot_free: assert (!pend_vld[m.id]) else begin
      errors = errors + 1;
      $display("Slot %0d issued again while still outstanding, at %0t", m.id, $time);
    end
  endtask

  initial begin : mem_req_side
    hub_pkg::mst_req_t m;
    forever begin
      @(negedge periph_clk);
      if (mst_req_o && !mst_ack_i) begin
        repeat (pick(3)) @(negedge periph_clk);
        m = mst_req_data_o;
        check_master_req(m);
        if (m.wr) mem[m.addr] = m.data;
        pend_vld[m.id]  = 1'b1;
        pend_data[m.id] = mem[m.addr];
        pend_err[m.id]  = (pick(4) == 0);  // Some responses flag an error
        exp_err[m.addr] = pend_err[m.id];
        n_out     = n_out + 1;
        mst_ack_i = 1'b1;
        @(negedge periph_clk);
        while (mst_req_o) @(negedge periph_clk);
        exp_mst_vld[m.addr] = 1'b0;
        n_mst     = n_mst + 1;
        mst_ack_i = 1'b0;
      end
    end
  end

  // Picks any outstanding slot, so responses come back out of order
  initial begin : mem_rsp_side
    int s;
    int start;
    forever begin
      @(negedge periph_clk);
      if (!hold_rsp && n_out > 0 && !mst_rsp_req_i && !mst_rsp_ack_o && pick(2) == 0) begin
        start = int'(pick(`HUB_SLOTS));
        s     = -1;
        for (int i = 0; i < `HUB_SLOTS; i++) begin
          if (s < 0 && pend_vld[(start + i) % `HUB_SLOTS]) s = (start + i) % `HUB_SLOTS;
        end
        mst_rsp_i.id   = hub_pkg::slot_id_t'(s);
        mst_rsp_i.data = pend_data[s];
        mst_rsp_i.err  = pend_err[s];
        mst_rsp_req_i  = 1'b1;
        @(negedge periph_clk);
        while (!mst_rsp_ack_o) @(negedge periph_clk);
        pend_vld[s]   = 1'b0;
        n_out         = n_out - 1;
        mst_rsp_req_i = 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Global checks
  ////////////////////////////////////////

  always @(posedge periph_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_seen <= 1'b0;
      ack_prev <= '0;
      for (int q = 0; q < `HUB_NUM_PORTS; q++) begin
        for (int p = 0; p < `HUB_NUM_PORTS; p++) pass_cnt_q[q][p] <= '0;
      end
    end else begin
      ack_prev <= port_ack_o;
      if (|port_req_i) req_seen <= 1'b1;
      // Acks given to port p while port q waits
      for (int q = 0; q < `HUB_NUM_PORTS; q++) begin
        for (int p = 0; p < `HUB_NUM_PORTS; p++) begin
          if (!port_req_i[q] || port_ack_o[q]) begin
            pass_cnt_q[q][p] <= '0;
          end else if (p != q && port_ack_o[p] && !ack_prev[p] && pass_cnt_q[q][p] != 2'd3) begin
            pass_cnt_q[q][p] <= pass_cnt_q[q][p] + 2'd1;
          end
        end
      end
    end
  end

  always_comb begin
    unfair = 1'b0;
    for (int q = 0; q < `HUB_NUM_PORTS; q++) begin
      for (int p = 0; p < `HUB_NUM_PORTS; p++) begin
        if (pass_cnt_q[q][p] >= 2'd2) unfair = 1'b1;
      end
    end
  end

  a_idle_low: assert property (@(posedge periph_clk) disable iff (!rst_n_i)
    !req_seen |-> (port_ack_o == '0 && port_rsp_req_o == '0 && !mst_req_o && !mst_rsp_ack_o))
    else begin
      errors = errors + 1;
      $display("Hub outputs went active before any request, at %0t", $time);
    end

  a_fair: assert property (@(posedge periph_clk) disable iff (!rst_n_i) !unfair)
    else begin
      errors = errors + 1;
      $display("A port was acked twice while another port waited, at %0t", $time);
    end

  a_slot_bound: assert property (@(posedge periph_clk) disable iff (!rst_n_i)
    n_out <= `HUB_SLOTS)
    else begin
      errors = errors + 1;
      $display("%0d master requests outstanding at %0t", $sampled(n_out), $time);
    end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  task automatic wait_drain();
    while (n_done != n_issued || n_out != 0) @(negedge periph_clk);
  endtask

  task automatic begin_test();
    err_mark = errors;
    test_num = test_num + 1;
  endtask

  task automatic end_test(input string name);
    if (errors == err_mark) begin
      pass_cnt = pass_cnt + 1;
      $display("[test %0d] %s ... passed", test_num, name);
    end else begin
      fail_cnt = fail_cnt + 1;
      $display("[test %0d] %s ... failed, %0d errors", test_num, name, errors - err_mark);
    end
  endtask

  initial begin : main
    rst_n_i         = 1'b0;
    port_req_i      = '0;
    port_req_data_i = '0;
    port_rsp_ack_i  = '0;
    mst_ack_i       = 1'b0;
    mst_rsp_req_i   = 1'b0;
    mst_rsp_i       = '0;
    hold_rsp        = 1'b0;
    rsp_slow        = 1'b0;
    pend_vld        = '0;
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a]         = '0;
      ref_mem[a]     = '0;
      addr_busy[a]   = 1'b0;
      exp_mst_vld[a] = 1'b0;
    end
    for (int p = 0; p < `HUB_NUM_PORTS; p++) begin
      exp_vld[p] = '0;
      out_cnt[p] = 0;
    end
    repeat (2) @(negedge periph_clk);
    rst_n_i = 1'b1;

    begin_test();
    repeat (6) @(negedge periph_clk);
    end_test("outputs low after reset");

    begin_test();
    issue_req(0, 1'b1, 'h40);
    wait_drain();
    issue_req(0, 1'b0, 'h40);
    wait_drain();
    end_test("single write then read on port 0");

    begin_test();
    run_all_ports(6, 0);
    wait_drain();
    compare_value("master request count", n_issued, n_mst);
    end_test("four ports requesting back to back");

    begin_test();
    hold_rsp = 1'b1;
    run_all_ports(2, 0);
    while (n_out < `HUB_SLOTS) @(negedge periph_clk);
    repeat (8) @(negedge periph_clk);
    compare_value("outstanding master requests", `HUB_SLOTS, n_out);
    hold_rsp = 1'b0;
    wait_drain();
    end_test("slot limit while responses are held");

    begin_test();
    run_all_ports(8, 4);
    wait_drain();
    end_test("mixed traffic with out-of-order responses");

    begin_test();
    rsp_slow = 1'b1;
    run_all_ports(5, 2);
    wait_drain();
    rsp_slow = 1'b0;
    compare_value("master request count", n_issued, n_mst);
    compare_value("port responses", n_issued, n_rsp);
    end_test("slow port response acks");

    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+hdl
hdl/hub_pkg.sv
hdl/port_arbiter.sv
hdl/req_fifo.sv
hdl/id_remap.sv
hdl/xbar_hub.sv
verification/tb_xbar_hub.sv

// ==== Bender.yml ====
package:
  name: xbar_hub

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/hub_pkg.sv
      - hdl/port_arbiter.sv
      - hdl/req_fifo.sv
      - hdl/id_remap.sv
      - hdl/xbar_hub.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - verification/tb_xbar_hub.sv
